// File: Makefile
TOP = tb_video_core

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module video_core \
	  logic/video_pkg.sv logic/vic_regs_pkg.sv logic/vic_regs.sv logic/pixel_fetch.sv \
	  logic/pixel_fifo.sv logic/video_out.sv logic/video_core.sv

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failed" sim.log; then \
	  echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: logic/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch
  import video_pkg::*;
#(
  parameter int mem_aw        = 12,
  parameter int fifo_depth    = 16,
  parameter int window_pixels = 48
) (
  input  logic                            clk_dot4x,
  input  logic                            reset,
  input  logic                            display_en,
  input  logic                            frame_start,
  output logic [mem_aw-1:0]               mem_addr,
  output logic                            mem_rd,
  input  logic [7:0]                      mem_data,   // valid one clock after mem_rd
  output logic                            push,
  output color_idx_t                      push_data,
  input  logic [$clog2(fifo_depth+1)-1:0] fifo_count
);

  localparam int cw = $clog2(fifo_depth + 1);

  logic [mem_aw-1:0] addr_q;    // next address, doubles as reads issued this frame
  logic [cw:0]       committed; // fifo words plus the reads still in flight
  logic              issue;

  // in flight is the read on the bus plus the byte being pushed
  assign committed = {1'b0, fifo_count} + (cw + 1)'(mem_rd) + (cw + 1)'(push);

  assign issue = display_en && !frame_start
              && (addr_q < mem_aw'(window_pixels))   // frame fully fetched
              && (committed < (cw + 1)'(fifo_depth)); // room for one more

  always_ff @(posedge clk_dot4x) begin
    if (reset) begin
      addr_q <= '0;
      mem_rd <= 1'b0;
      push   <= 1'b0;
    end else begin
      mem_rd <= issue;
      push   <= mem_rd && !frame_start; // a read across the flush is thrown away
      if (frame_start)
        addr_q <= '0; // restart at the top of video memory
      else if (issue)
        addr_q <= addr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_dot4x) begin
    if (issue) mem_addr <= addr_q;
  end

  assign push_data = mem_data[3:0]; // raw index, background applied at output

  // credit check has to cover the fifo's one cycle count lag
  assert property (@(posedge clk_dot4x) disable iff (reset)
    push |-> fifo_count != cw'(fifo_depth))
    else $error("fetch pushed into a full pixel fifo");

endmodule : pixel_fetch

// File: logic/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo
  import video_pkg::*;
#(
  parameter int fifo_depth = 16 // power of two
) (
  input  logic                            clk_dot4x,
  input  logic                            reset,
  input  logic                            flush,
  input  logic                            push,
  input  color_idx_t                      push_data,
  input  logic                            pop,
  output color_idx_t                      pop_data,  // head word, valid while not empty
  output logic                            empty,
  output logic                            full,
  output logic [$clog2(fifo_depth+1)-1:0] count
);

  localparam int aw = $clog2(fifo_depth);

  color_idx_t    mem [fifo_depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic          wr_en;
  logic          rd_en;

  assign wr_en = push && !flush; // flush beats a push in the same clock
  assign rd_en = pop && !flush;

  always_ff @(posedge clk_dot4x) begin
    if (wr_en) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk_dot4x) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ; // both or neither
      endcase
    end
  end

  assign pop_data = mem[rd_ptr];
  assign empty    = count == '0;
  assign full     = count == fifo_depth[$clog2(fifo_depth+1)-1:0];

  assert property (@(posedge clk_dot4x) disable iff (reset) push |-> !full)
    else $error("pixel fifo overflow");
  assert property (@(posedge clk_dot4x) disable iff (reset) pop |-> !empty)
    else $error("pixel fifo underflow");

endmodule : pixel_fifo

// File: logic/vic_regs.sv
`timescale 1ns/1ps

module vic_regs
  import video_pkg::*;
  import vic_regs_pkg::*;
(
  input  logic        clk_dot4x,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic [8:0]  raster_line,  // current line from the raster stage
  output logic        display_en,
  output color_idx_t  border_color,
  output color_idx_t  bg_color,
  output logic        irq
);

  logic [1:0]  ctrl_q;        // display enable and irq enable
  color_idx_t  border_q;
  color_idx_t  bg_q;
  logic [8:0]  raster_cmp_q;
  logic        irq_pending;   // sticky, cleared by write one
  logic [8:0]  line_q;        // raster line seen on the previous clock
  logic        access;
  logic        addr_ok;
  logic        line_start;
  logic [31:0] rdata;

  assign access     = psel && penable;   // second apb phase
  assign line_start = raster_line != line_q;

  // offset decode, shared by read and write
  always_comb begin
    addr_ok = 1'b1;
    rdata   = '0;
    case ({24'h0, paddr})
      reg_ctrl:       rdata = 32'(ctrl_q);
      reg_border:     rdata = 32'(border_q);
      reg_bg:         rdata = 32'(bg_q);
      reg_raster_cmp: rdata = 32'(raster_cmp_q);
      reg_status:     rdata = 32'(irq_pending);
      default:        addr_ok = 1'b0; // unmapped offset reads as zero
    endcase
  end

  always_ff @(posedge clk_dot4x) begin
    if (reset) begin
      ctrl_q       <= '0;
      border_q     <= '0;
      bg_q         <= '0;
      raster_cmp_q <= '0;
      irq_pending  <= 1'b0;
      line_q       <= '1; // so line 0 after reset counts as a new line
    end else begin
      line_q <= raster_line;
      if (access && pwrite) begin
        case ({24'h0, paddr})
          reg_ctrl: begin
            ctrl_q[ctrl_display_en_bit] <= pwdata[ctrl_display_en_bit];
            ctrl_q[ctrl_irq_en_bit]     <= pwdata[ctrl_irq_en_bit];
          end
          reg_border:     border_q     <= pwdata[3:0];
          reg_bg:         bg_q         <= pwdata[3:0];
          reg_raster_cmp: raster_cmp_q <= pwdata[8:0];
          reg_status:     if (pwdata[0]) irq_pending <= 1'b0;
          default:        ; // write dropped and flagged by pslverr
        endcase
      end
      if (line_start && raster_line == raster_cmp_q)
        irq_pending <= 1'b1; // a new match wins over a clear in the same cycle
    end
  end

  assign pready       = 1'b1; // zero wait states
  assign pslverr      = access && !addr_ok;
  assign prdata       = access ? rdata : '0;
  assign display_en   = ctrl_q[ctrl_display_en_bit];
  assign border_color = border_q;
  assign bg_color     = bg_q;
  assign irq          = irq_pending && ctrl_q[ctrl_irq_en_bit];

  // a rejected write leaves the register file alone
  assert property (@(posedge clk_dot4x) disable iff (reset)
    pslverr && pwrite |=> $stable({ctrl_q, border_q, bg_q, raster_cmp_q}))
    else $error("write answered with pslverr changed a register");

endmodule : vic_regs

// File: logic/vic_regs_pkg.sv
package vic_regs_pkg;

  // byte offsets on the apb bus
  localparam logic [31:0] reg_ctrl       = 32'h0000_0000;
  localparam logic [31:0] reg_border     = 32'h0000_0004;
  localparam logic [31:0] reg_bg         = 32'h0000_0008;
  localparam logic [31:0] reg_raster_cmp = 32'h0000_000c;
  localparam logic [31:0] reg_status     = 32'h0000_0010; // bit 0 irq pending, write 1 clears

  // ctrl register fields
  localparam logic [31:0] ctrl_display_en_bit = 32'd0;
  localparam logic [31:0] ctrl_irq_en_bit     = 32'd1;

endpackage : vic_regs_pkg

// File: logic/video_core.sv
`timescale 1ns/1ps

module video_core
  import video_pkg::*;
#(
  parameter int h_visible  = 64,
  parameter int h_total    = 80,
  parameter int v_visible  = 48,
  parameter int v_total    = 56,
  parameter int border     = 8,
  parameter int fifo_depth = 16,
  parameter int mem_aw     = 12
) (
  input  logic              clk_dot4x,
  input  logic              reset,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [7:0]        paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic [mem_aw-1:0] mem_addr,
  output logic              mem_rd,
  input  logic [7:0]        mem_data,
  output logic              irq,
  output logic              hsync,
  output logic              vsync,
  output logic              active,
  output logic [3:0]        red,
  output logic [3:0]        green,
  output logic [3:0]        blue
);

  localparam int window_pixels = (h_visible - 2 * border) * (v_visible - 2 * border);
  localparam int cw            = $clog2(fifo_depth + 1);

  logic          display_en;
  color_idx_t    border_color;
  color_idx_t    bg_color;
  logic [8:0]    raster_line;
  logic          frame_start;   // flushes the fifo and rewinds the fetch
  logic          push;
  color_idx_t    push_data;
  logic          pop;
  color_idx_t    pop_data;
  logic          empty;
  logic [cw-1:0] fifo_count;

  vic_regs u_regs (
    .clk_dot4x, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .raster_line, .display_en,
    .border_color, .bg_color, .irq
  );

  pixel_fetch #(.mem_aw(mem_aw), .fifo_depth(fifo_depth), .window_pixels(window_pixels))
  u_fetch (
    .clk_dot4x, .reset, .display_en, .frame_start, .mem_addr, .mem_rd, .mem_data,
    .push, .push_data, .fifo_count
  );

  pixel_fifo #(.fifo_depth(fifo_depth)) u_fifo (
    .clk_dot4x, .reset, .flush(frame_start), .push, .push_data, .pop, .pop_data,
    .empty, .full(), .count(fifo_count) // fetch paces itself from count
  );

  video_out #(
    .h_visible(h_visible), .h_total(h_total), .v_visible(v_visible),
    .v_total(v_total), .border(border)
  ) u_out (
    .clk_dot4x, .reset, .display_en, .border_color, .bg_color, .pop, .pop_data,
    .empty, .frame_start, .raster_line, .hsync, .vsync, .active, .red, .green, .blue
  );

endmodule : video_core

// File: logic/video_out.sv
`timescale 1ns/1ps

module video_out
  import video_pkg::*;
#(
  parameter int h_visible = 64,
  parameter int h_total   = 80,
  parameter int v_visible = 48,
  parameter int v_total   = 56,
  parameter int border    = 8   // window inset in pixels and lines
) (
  input  logic       clk_dot4x,
  input  logic       reset,
  input  logic       display_en,
  input  color_idx_t border_color,
  input  color_idx_t bg_color,
  output logic       pop,
  input  color_idx_t pop_data,
  input  logic       empty,
  output logic       frame_start,
  output logic [8:0] raster_line,
  output logic       hsync,
  output logic       vsync,
  output logic       active,
  output logic [3:0] red,
  output logic [3:0] green,
  output logic [3:0] blue
);

  localparam int hw = $clog2(h_total);
  localparam int vw = $clog2(v_total);

  logic [hw-1:0] h_cnt;
  logic [vw-1:0] v_cnt;
  logic          frame_en;  // display enable sampled at frame start
  logic          visible;
  logic          in_window;
  rgb_t          pix;

  always_ff @(posedge clk_dot4x) begin
    if (reset) begin
      h_cnt    <= '0;
      v_cnt    <= '0;
      frame_en <= 1'b0;
    end else begin
      if (h_cnt == hw'(h_total - 1)) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == vw'(v_total - 1)) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
      if (frame_start) frame_en <= display_en; // fifo is refilled from here on
    end
  end

  assign visible   = (h_cnt < hw'(h_visible)) && (v_cnt < vw'(v_visible));
  assign in_window = (h_cnt >= hw'(border)) && (h_cnt < hw'(h_visible - border))
                  && (v_cnt >= vw'(border)) && (v_cnt < vw'(v_visible - border));

  assign pop         = in_window && frame_en && display_en; // one index per pixel
  assign frame_start = (h_cnt == '0) && (v_cnt == vw'(v_total - 1)); // last blank line
  assign raster_line = 9'(v_cnt);

  always_comb begin
    if (!visible)
      pix = '0;                                           // blanking is black
    else if (pop)
      pix = palette_rgb((pop_data == '0) ? bg_color : pop_data);
    else
      pix = palette_rgb(border_color);
  end

  // outputs lag the counters by one clock
  always_ff @(posedge clk_dot4x) begin
    if (reset) begin
      hsync              <= 1'b0;
      vsync              <= 1'b0;
      active             <= 1'b0;
      {red, green, blue} <= '0;
    end else begin
      hsync              <= (h_cnt >= hw'(h_visible)) && (h_cnt <= hw'(h_visible + 1));
      vsync              <= v_cnt == vw'(v_visible);
      active             <= visible;
      {red, green, blue} <= pix;
    end
  end

  // a full window must be prefetched before the first window line
  assert property (@(posedge clk_dot4x) disable iff (reset) pop |-> !empty)
    else $error("raster reached the window before the fetch caught up");

endmodule : video_out

// File: logic/video_pkg.sv
package video_pkg;

  typedef logic [3:0]  color_idx_t; // palette index, 0 is transparent in the window
  typedef logic [11:0] rgb_t;       // {red, green, blue}, 4 bits each

  // c64-like colors squeezed into 4 bits per gun
  localparam rgb_t palette [16] = '{
    12'h000, // black
    12'hfff, // white
    12'h833, // red
    12'h7cc, // cyan
    12'h849, // purple
    12'h5a4, // green
    12'h439, // blue
    12'hbc7, // yellow
    12'h852, // orange
    12'h540, // brown
    12'hb66, // light red
    12'h444, // dark grey
    12'h777, // mid grey
    12'h9e8, // light green
    12'h76c, // light blue
    12'haaa  // light grey
  };

  function automatic rgb_t palette_rgb(color_idx_t idx);
    return palette[idx];
  endfunction

endpackage : video_pkg

// File: tests/tb_video_core.sv
`timescale 1ns/1ps

module tb_video_core
  import video_pkg::*;
  import vic_regs_pkg::*;
;

  logic        clk_dot4x;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [11:0] mem_addr;
  logic        mem_rd;
  logic [7:0]  mem_data = '0;
  logic        irq;
  logic        hsync;
  logic        vsync;
  logic        active;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;

  logic [7:0]  vmem [4096];      // video memory behind the ado/dbi style bus
  integer      seed = 32'h4de0e9ce;
  int          exp_idx [8][16];  // expected visible frame with -1 for border
  int          wr_phase [$];     // register writes from the pattern file
  logic [7:0]  wr_off [$];
  logic [31:0] wr_data [$];
  logic [7:0]  err_off [$];      // offsets that must answer with pslverr
  color_idx_t  border_now = '0;  // colors last written over apb
  color_idx_t  bg_now = '0;

  video_core #(
    .h_visible(16), .h_total(24), .v_visible(8), .v_total(12), .border(2),
    .fifo_depth(16), .mem_aw(12)
  ) dut (
    .clk_dot4x, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .pslverr, .mem_addr, .mem_rd, .mem_data, .irq, .hsync, .vsync, .active,
    .red, .green, .blue
  );

  initial begin
    clk_dot4x = 1'b0;
    forever #10 clk_dot4x = ~clk_dot4x;
  end

  always @(posedge clk_dot4x) begin
    if (mem_rd) mem_data <= vmem[mem_addr]; // data one clock after the read strobe
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    fail_now($sformatf("[FAIL] %0t %s", $time, msg));
  endtask

  task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  function automatic int hex_value(input logic [7:0] c);
    if (c >= "0" && c <= "9") return int'(c - "0");
    if (c >= "a" && c <= "f") return int'(c - "a") + 10;
    return -2; // not a pixel character
  endfunction

  task automatic load_patterns();
    int          fd;
    int          code;
    int          rows;
    int          v;
    string       kw;
    string       text;
    logic [11:0] a;
    logic [7:0]  b;
    logic [31:0] d;
    rows = 0;
    for (int i = 0; i < 4096; i++) vmem[i] = 8'($random(seed)); // whatever lies past the window
    fd = $fopen("tests/video_patterns.txt", "r");
    if (fd == 0) fail_now("could not open tests/video_patterns.txt");
    while ($fscanf(fd, "%s", kw) == 1) begin
      if (kw == "#") begin
        code = $fgets(text, fd); // rest of a comment line
      end else if (kw == "mem") begin
        code = $fscanf(fd, "%h", a);
        for (int i = 0; i < 12; i++) begin
          code = $fscanf(fd, "%h", b);
          vmem[a + 12'(i)] = b;
        end
      end else if (kw == "wr") begin
        code = $fscanf(fd, "%d %h %h", v, b, d);
        wr_phase.push_back(v);
        wr_off.push_back(b);
        wr_data.push_back(d);
      end else if (kw == "err") begin
        code = $fscanf(fd, "%h", b);
        err_off.push_back(b);
      end else if (kw == "row") begin
        code = $fscanf(fd, "%s", text);
        if (text.len() != 16 || rows > 7) fail_now("bad expected row in the pattern file");
        for (int i = 0; i < 16; i++) begin
          v = (text[i] == "B") ? -1 : hex_value(text[i]);
          if (v == -2) fail_now("unknown pixel character in the pattern file");
          exp_idx[rows][i] = v;
        end
        rows++;
      end else begin
        fail_now($sformatf("unknown record %s in the pattern file", kw));
      end
    end
    $fclose(fd);
  endtask

  // setup phase then access phase until pready
  task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    @(posedge clk_dot4x);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk_dot4x);
    penable <= 1'b1;
    do begin
      @(negedge clk_dot4x);
      n++;
      if (n > 16) fail_now("apb access never completed, pready stayed low");
    end while (!pready);
    rdata = prdata; // sampled mid access phase
    err   = pslverr;
    @(posedge clk_dot4x);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    check_bit(err, 1'b0, $sformatf("pslverr on write to %h", addr));
  endtask

  task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_bit(err, 1'b0, $sformatf("pslverr on read of %h", addr));
    check_word(rdata, exp, $sformatf("readback of %h", addr));
  endtask

  task automatic apply_writes(input int phase);
    foreach (wr_phase[i]) begin
      if (wr_phase[i] == phase) begin
        reg_write(wr_off[i], wr_data[i]);
        reg_check(wr_off[i], wr_data[i]); // file values stay inside the field widths
        if (wr_off[i] == reg_border[7:0]) border_now = wr_data[i][3:0];
        if (wr_off[i] == reg_bg[7:0]) bg_now = wr_data[i][3:0];
      end
    end
  endtask

  task automatic wait_vsync(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk_dot4x);
      n++;
      if (n > 1000) fail_now($sformatf("timeout, vsync never went to %0d", level));
    end while (vsync !== level);
  endtask

  task automatic wait_irq_high();
    int n;
    n = 0;
    do begin
      @(negedge clk_dot4x);
      n++;
      if (n > 1000) fail_now("timeout, irq never rose");
    end while (irq !== 1'b1);
  endtask

  // checks one whole frame after the next vsync with irq high from irq_line on
  task automatic scan_frame(input bit use_rows, input int irq_line);
    int   n;
    int   px;
    int   line;
    int   col;
    int   idx;
    logic prev_active;
    rgb_t exp;
    n = 0;
    px = 0;
    line = -1; // blank lines before raster line 0
    col = 0;
    prev_active = 1'b0;
    wait_vsync(1'b0);
    wait_vsync(1'b1);
    wait_vsync(1'b0);
    while (px < 128) begin
      @(negedge clk_dot4x);
      n++;
      if (n > 400) fail_now("timeout, the visible area of a frame never completed");
      if (active && !prev_active) begin
        line++;
        col = 0; // first column of a visible line
      end else begin
        col++;
      end
      prev_active = active;
      check_bit(irq, (irq_line >= 0) && (line >= irq_line), $sformatf("irq on line %0d", line));
      if (line >= 0) begin
        check_bit(active, col < 16, $sformatf("active at column %0d of line %0d", col, line));
        check_bit(hsync, (col == 16) || (col == 17),
                  $sformatf("hsync at column %0d of line %0d", col, line));
        check_bit(vsync, 1'b0, $sformatf("vsync on visible line %0d", line));
      end
      if (!active) begin
        check_rgb({red, green, blue}, '0, "blanking pixel");
      end else begin
        idx = use_rows ? exp_idx[line][px % 16] : -1;
        if (idx < 0) exp = palette_rgb(border_now);
        else if (idx == 0) exp = palette_rgb(bg_now); // transparent shows background
        else exp = palette_rgb(color_idx_t'(idx));
        check_rgb({red, green, blue}, exp, $sformatf("pixel %0d of line %0d", px % 16, line));
        px++;
      end
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    load_patterns();
    repeat (10) @(posedge clk_dot4x);
    reset <= 1'b0;

    scan_frame(1'b0, -1); // display off gives border 0 everywhere and no irq

    foreach (err_off[i]) begin
      apb_access(1'b0, err_off[i], '0, rdata, err);
      check_bit(err, 1'b1, "pslverr on unknown read");
      check_word(rdata, '0, "prdata on unknown read");
      apb_access(1'b1, err_off[i], 32'hffff_ffff, rdata, err);
      check_bit(err, 1'b1, "pslverr on unknown write");
    end
    reg_check(reg_ctrl[7:0], '0); // dropped writes left the map alone
    reg_check(reg_border[7:0], '0);

    apply_writes(1); // display on
    scan_frame(1'b1, -1);
    apply_writes(2); // new border and background
    scan_frame(1'b1, -1);

    reg_write(reg_raster_cmp[7:0], 32'd3);
    reg_write(reg_ctrl[7:0], 32'h3);
    wait_irq_high();
    reg_write(reg_status[7:0], 32'h1);
    wait_irq_high(); // now at the start of line 3
    reg_write(reg_status[7:0], 32'h1);
    @(negedge clk_dot4x);
    check_bit(irq, 1'b0, "irq after clear");
    scan_frame(1'b1, 3);
    @(negedge clk_dot4x);
    check_bit(irq, 1'b1, "irq held until cleared");
    reg_check(reg_status[7:0], 32'h1);
    reg_write(reg_status[7:0], 32'h1);
    @(negedge clk_dot4x);
    check_bit(irq, 1'b0, "irq after second clear");
    reg_write(reg_ctrl[7:0], 32'h1); // irq enable off while pending still sets
    scan_frame(1'b1, -1);

    $display("Test completed successfully");
    $finish;
  end

endmodule : tb_video_core

// File: tests/video_patterns.txt
# mem <addr> <12 bytes> | wr <phase> <offset> <data> | err <offset> | row <16 pixels>
# phase 1 turns the display on, phase 2 recolors; pixels are hex indices, B is border
mem 000 31 42 53 64 75 86 97 a8 b9 ca db ec
mem 00c fd 0e 1f 20 00 f0 05 15 25 35 45 55
mem 018 10 21 32 43 54 65 76 87 98 a9 ba cb
mem 024 0c 1d 2e 3f 40 e1 f2 03 60 77 88 f0
wr 1 004 0000000e
wr 1 008 00000006
wr 1 00c 00000005
wr 1 000 00000001
wr 2 004 00000002
wr 2 008 0000000b
err 014
err 0ff
row BBBBBBBBBBBBBBBB
row BBBBBBBBBBBBBBBB
row BB123456789abcBB
row BBdef000555555BB
row BB0123456789abBB
row BBcdef01230780BB
row BBBBBBBBBBBBBBBB
row BBBBBBBBBBBBBBBB

// File: vlog.f
logic/video_pkg.sv
logic/vic_regs_pkg.sv
logic/vic_regs.sv
logic/pixel_fetch.sv
logic/pixel_fifo.sv
logic/video_out.sv
logic/video_core.sv
tests/tb_video_core.sv
